// File: design/ntm_macros.svh
`ifndef NTM_MACROS_SVH
`define NTM_MACROS_SVH

// Q8.8 operands and results
`define NTM_DATA_W 16
`define NTM_FRAC_W 8

// Full precision sum of Q16.16 products plus headroom
`define NTM_ACC_W 40

// Vector sizes and index fields
`define NTM_SIZE_MAX 8
`define NTM_SIZE_W 4

// Piecewise-linear tanh breakpoints, Q8.8
`define NTM_TANH_KNEE 128
`define NTM_TANH_SAT 384
`define NTM_ONE 256

`endif

// File: design/ntm_pkg.sv
`include "ntm_macros.svh"

package ntm_pkg;

  // Controller phases of one output element
  typedef enum logic [2:0] {
    IDLE,
    PROD_WX,
    PROD_KR,
    PROD_UH,
    BIAS,
    TANH,
    DONE
  } ntm_state_e;

  // Accumulator commands
  typedef enum logic [1:0] {
    MAC_HOLD,
    MAC_CLEAR,
    MAC_ACC,
    MAC_BIAS
  } ntm_mac_op_e;

  // Matrix entry and vector entry, or bias in a
  typedef struct packed {
    logic signed [`NTM_DATA_W-1:0] a;
    logic signed [`NTM_DATA_W-1:0] b;
  } ntm_operand_t;

  // One tanh output with its element number
  typedef struct packed {
    logic [`NTM_SIZE_W-1:0]        index;
    logic signed [`NTM_DATA_W-1:0] value;
  } ntm_result_t;

  typedef struct packed {
    logic [`NTM_SIZE_W-1:0] x;
    logic [`NTM_SIZE_W-1:0] w;
    logic [`NTM_SIZE_W-1:0] l;
  } ntm_sizes_t;

endpackage

// File: design/ntm_gate_controller.sv
`include "ntm_macros.svh"

module ntm_gate_controller (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  ntm_pkg::ntm_sizes_t  sizes,
  input  logic                 operand_valid,
  output logic                 operand_ready,
  input  logic                 term_last,
  input  logic                 elem_last,
  output logic                 count_load,
  output logic                 term_step,
  output logic                 elem_step,
  output ntm_pkg::ntm_state_e  phase,
  output ntm_pkg::ntm_mac_op_e mac_op,
  output logic                 tanh_go,
  output logic                 ready
);

  ntm_pkg::ntm_state_e state;
  ntm_pkg::ntm_state_e state_nxt;
  logic                sizes_ok;
  logic                transfer;

  ////////////////////////////////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////////////////////////////////

  // A START with an empty or oversized vector is ignored
  assign sizes_ok = (sizes.x != '0) && (sizes.x <= `NTM_SIZE_MAX) &&
                    (sizes.w != '0) && (sizes.w <= `NTM_SIZE_MAX) &&
                    (sizes.l != '0) && (sizes.l <= `NTM_SIZE_MAX);

  // Operands taken in the three product phases and the bias phase
  assign operand_ready = (state == ntm_pkg::PROD_WX) || (state == ntm_pkg::PROD_KR) ||
                         (state == ntm_pkg::PROD_UH) || (state == ntm_pkg::BIAS);
  assign transfer      = operand_valid && operand_ready;

  assign count_load = (state == ntm_pkg::IDLE) && start && sizes_ok;
  assign term_step  = transfer;
  // Last element leaves the index alone, next START reloads it
  assign elem_step  = (state == ntm_pkg::TANH) && !elem_last;
  assign tanh_go    = (state == ntm_pkg::TANH);
  assign ready      = (state == ntm_pkg::DONE);
  assign phase      = state;

  ////////////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ntm_pkg::IDLE:    if (count_load) state_nxt = ntm_pkg::PROD_WX;
      ntm_pkg::PROD_WX: if (transfer && term_last) state_nxt = ntm_pkg::PROD_KR;
      ntm_pkg::PROD_KR: if (transfer && term_last) state_nxt = ntm_pkg::PROD_UH;
      ntm_pkg::PROD_UH: if (transfer && term_last) state_nxt = ntm_pkg::BIAS;
      ntm_pkg::BIAS:    if (transfer && term_last) state_nxt = ntm_pkg::TANH;
      // Result registered here, then next element or finish
      ntm_pkg::TANH:    state_nxt = elem_last ? ntm_pkg::DONE : ntm_pkg::PROD_WX;
      ntm_pkg::DONE:    state_nxt = ntm_pkg::IDLE;
      default:          state_nxt = ntm_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Accumulator command per cycle
  always_comb begin
    mac_op = ntm_pkg::MAC_HOLD;
    case (state)
      ntm_pkg::IDLE: begin
        if (count_load) mac_op = ntm_pkg::MAC_CLEAR;
      end
      ntm_pkg::PROD_WX, ntm_pkg::PROD_KR, ntm_pkg::PROD_UH: begin
        if (transfer) mac_op = ntm_pkg::MAC_ACC;
      end
      ntm_pkg::BIAS: begin
        if (transfer) mac_op = ntm_pkg::MAC_BIAS;
      end
      // Sum register keeps its value, only the accumulator clears
      ntm_pkg::TANH: begin
        if (!elem_last) mac_op = ntm_pkg::MAC_CLEAR;
      end
      default: mac_op = ntm_pkg::MAC_HOLD;
    endcase
  end

endmodule

// File: design/ntm_element_counter.sv
`include "ntm_macros.svh"

module ntm_element_counter (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   count_load,
  input  ntm_pkg::ntm_sizes_t    sizes,
  input  ntm_pkg::ntm_state_e    phase,
  input  logic                   term_step,
  input  logic                   elem_step,
  output logic                   term_last,
  output logic                   elem_last,
  output logic [`NTM_SIZE_W-1:0] elem_index
);

  ntm_pkg::ntm_sizes_t    sizes_q;
  logic [`NTM_SIZE_W-1:0] term_cnt;
  logic [`NTM_SIZE_W-1:0] elem_cnt;
  logic [`NTM_SIZE_W-1:0] term_limit;

  // Terms per phase, bias is a single operand
  always_comb begin
    case (phase)
      ntm_pkg::PROD_WX: term_limit = sizes_q.x;
      ntm_pkg::PROD_KR: term_limit = sizes_q.w;
      ntm_pkg::PROD_UH: term_limit = sizes_q.l;
      default:          term_limit = `NTM_SIZE_W'(1);
    endcase
  end

  assign term_last  = (term_cnt == term_limit - 1'b1);
  assign elem_last  = (elem_cnt == sizes_q.l - 1'b1);
  assign elem_index = elem_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sizes_q  <= '0;
      term_cnt <= '0;
      elem_cnt <= '0;
    end else if (count_load) begin
      sizes_q  <= sizes;
      term_cnt <= '0;
      elem_cnt <= '0;
    end else begin
      // Wrap at phase end so the next phase starts from zero
      if (term_step) term_cnt <= term_last ? '0 : term_cnt + 1'b1;
      if (elem_step) elem_cnt <= elem_cnt + 1'b1;
    end
  end

endmodule

// File: design/ntm_mac_unit.sv
`include "ntm_macros.svh"

module ntm_mac_unit (
  input  logic                          CLK,
  input  logic                          RST,
  input  ntm_pkg::ntm_mac_op_e          mac_op,
  input  ntm_pkg::ntm_operand_t         operand,
  output logic signed [`NTM_DATA_W-1:0] sum
);

  // Saturation bounds of the Q8.8 output, extended to accumulator width
  localparam logic signed [`NTM_ACC_W-1:0] SAT_MAX = 2 ** (`NTM_DATA_W - 1) - 1;
  localparam logic signed [`NTM_ACC_W-1:0] SAT_MIN = -(2 ** (`NTM_DATA_W - 1));

  logic signed [2*`NTM_DATA_W-1:0] product;
  logic signed [`NTM_ACC_W-1:0]    product_ext;
  logic signed [`NTM_ACC_W-1:0]    bias_ext;
  logic signed [`NTM_ACC_W-1:0]    acc;
  logic signed [`NTM_ACC_W-1:0]    biased;
  logic signed [`NTM_ACC_W-1:0]    scaled;
  logic signed [`NTM_DATA_W-1:0]   sat;

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  // Q8.8 times Q8.8 gives Q16.16
  assign product     = $signed(operand.a) * $signed(operand.b);
  assign product_ext = product;

  // Bias aligned to Q16.16, field b unused here
  assign bias_ext = $signed(operand.a);
  assign biased   = acc + (bias_ext <<< `NTM_FRAC_W);

  // Back to Q8.8
  assign scaled = biased >>> `NTM_FRAC_W;

  always_comb begin
    if (scaled > SAT_MAX) begin
      sat = SAT_MAX[`NTM_DATA_W-1:0];
    end else if (scaled < SAT_MIN) begin
      sat = SAT_MIN[`NTM_DATA_W-1:0];
    end else begin
      sat = scaled[`NTM_DATA_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Accumulator and final sum
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
      sum <= '0;
    end else begin
      case (mac_op)
        ntm_pkg::MAC_CLEAR: acc <= '0;
        ntm_pkg::MAC_ACC:   acc <= acc + product_ext;
        ntm_pkg::MAC_BIAS: begin
          acc <= biased;
          sum <= sat;
        end
        default: acc <= acc;
      endcase
    end
  end

endmodule

// File: design/ntm_tanh_unit.sv
`include "ntm_macros.svh"

module ntm_tanh_unit (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          go,
  input  logic signed [`NTM_DATA_W-1:0] sum,
  input  logic [`NTM_SIZE_W-1:0]        elem_index,
  output ntm_pkg::ntm_result_t          result,
  output logic                          result_valid
);

  logic                          neg;
  // One extra bit so the most negative input has a magnitude
  logic [`NTM_DATA_W:0]          mag;
  logic [`NTM_DATA_W:0]          mag_out;
  logic signed [`NTM_DATA_W-1:0] value;

  assign neg = sum[`NTM_DATA_W-1];
  assign mag = neg ? -{sum[`NTM_DATA_W-1], sum} : {1'b0, sum};

  // Three segments: slope 1, slope 1/2, flat at one
  always_comb begin
    if (mag < `NTM_TANH_KNEE) begin
      mag_out = mag;
    end else if (mag < `NTM_TANH_SAT) begin
      mag_out = (mag >> 1) + (`NTM_TANH_KNEE / 2);
    end else begin
      mag_out = `NTM_ONE;
    end
  end

  // Odd function, sign back on
  assign value = neg ? -mag_out[`NTM_DATA_W-1:0] : mag_out[`NTM_DATA_W-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= go;
      if (go) begin
        result.index <= elem_index;
        result.value <= value;
      end
    end
  end

endmodule

// File: design/ntm_activation_gate_vector.sv
`include "ntm_macros.svh"

module ntm_activation_gate_vector (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  ntm_pkg::ntm_sizes_t   SIZES,
  input  logic                  OPERAND_VALID,
  input  ntm_pkg::ntm_operand_t OPERAND,
  output logic                  OPERAND_READY,
  output logic                  RESULT_VALID,
  output ntm_pkg::ntm_result_t  RESULT,
  output logic                  READY
);

  ////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////

  // Counter control
  logic                          count_load;
  logic                          term_step;
  logic                          elem_step;
  logic                          term_last;
  logic                          elem_last;
  logic [`NTM_SIZE_W-1:0]        elem_index;
  ntm_pkg::ntm_state_e           phase;

  // Datapath control
  ntm_pkg::ntm_mac_op_e          mac_op;
  logic                          tanh_go;
  logic signed [`NTM_DATA_W-1:0] sum;

  ////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////

  // Phase sequencing and operand handshake
  ntm_gate_controller u_controller (
    .CLK           (CLK),
    .RST           (RST),
    .start         (START),
    .sizes         (SIZES),
    .operand_valid (OPERAND_VALID),
    .operand_ready (OPERAND_READY),
    .term_last     (term_last),
    .elem_last     (elem_last),
    .count_load    (count_load),
    .term_step     (term_step),
    .elem_step     (elem_step),
    .phase         (phase),
    .mac_op        (mac_op),
    .tanh_go       (tanh_go),
    .ready         (READY)
  );

  // Term and element indices
  ntm_element_counter u_counter (
    .CLK        (CLK),
    .RST        (RST),
    .count_load (count_load),
    .sizes      (SIZES),
    .phase      (phase),
    .term_step  (term_step),
    .elem_step  (elem_step),
    .term_last  (term_last),
    .elem_last  (elem_last),
    .elem_index (elem_index)
  );

  // Weighted sum of all three products plus bias
  ntm_mac_unit u_mac (
    .CLK     (CLK),
    .RST     (RST),
    .mac_op  (mac_op),
    .operand (OPERAND),
    .sum     (sum)
  );

  // Activation and result register
  ntm_tanh_unit u_tanh (
    .CLK          (CLK),
    .RST          (RST),
    .go           (tanh_go),
    .sum          (sum),
    .elem_index   (elem_index),
    .result       (RESULT),
    .result_valid (RESULT_VALID)
  );

endmodule

// File: tb/ntm_gate_assertions.sv
`include "ntm_macros.svh"

module ntm_gate_assertions (
  input logic                          CLK,
  input logic                          RST,
  input logic                          start_accepted,
  input logic                          operand_ready,
  input logic                          result_valid,
  input logic signed [`NTM_DATA_W-1:0] result_value,
  input logic                          ready
);

  // Stream stays closed once the vector is done
  ready_then_closed: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !operand_ready)
    else $error("OPERAND_READY high in the cycle after READY");

  // New run never overlaps the tail of the previous one
  start_outside_tail: assert property (@(posedge CLK) disable iff (RST)
    start_accepted |-> !result_valid && !ready)
    else $error("START accepted while RESULT_VALID or READY is high");

  // Tanh output bounded by one
  result_bounded: assert property (@(posedge CLK) disable iff (RST)
    result_valid |-> (result_value <= `NTM_ONE) && (result_value >= -`NTM_ONE))
    else $error("RESULT.value magnitude above one");

  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("READY high for more than one cycle");

endmodule

bind ntm_activation_gate_vector ntm_gate_assertions i_assertions (
  .CLK            (CLK),
  .RST            (RST),
  .start_accepted (count_load),
  .operand_ready  (OPERAND_READY),
  .result_valid   (RESULT_VALID),
  .result_value   (RESULT.value),
  .ready          (READY)
);

// File: tb/ntm_gate_tb.sv
`include "ntm_macros.svh"

module ntm_gate_tb;

  logic                   CLK = 1'b0;
  logic                   RST;
  logic                   START;
  ntm_pkg::ntm_sizes_t    SIZES;
  logic                   OPERAND_VALID;
  ntm_pkg::ntm_operand_t  OPERAND;
  logic                   OPERAND_READY;
  logic                   RESULT_VALID;
  ntm_pkg::ntm_result_t   RESULT;
  logic                   READY;

  // Operand stream of one run and expected values in element order
  logic [`NTM_DATA_W-1:0] op_a[$];
  logic [`NTM_DATA_W-1:0] op_b[$];
  logic [`NTM_DATA_W-1:0] exp_all[$];
  logic [`NTM_DATA_W-1:0] exp_q[$];
  logic [`NTM_DATA_W-1:0] popped;
  logic [63:0]            tag;
  logic [8*128-1:0]       line;
  logic                   bias_taken;
  integer                 fd;
  integer                 code;
  integer                 seed;
  integer                 cycles;
  integer                 limit;
  integer                 xfers;
  integer                 elem_ops;
  integer                 exp_index;
  integer                 mismatch_errors;
  integer                 protocol_errors;
  integer                 x;
  integer                 w;
  integer                 l;
  integer                 arg;
  integer                 e;
  integer                 r;
  integer                 done;

  ntm_activation_gate_vector i_dut (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .SIZES         (SIZES),
    .OPERAND_VALID (OPERAND_VALID),
    .OPERAND       (OPERAND),
    .OPERAND_READY (OPERAND_READY),
    .RESULT_VALID  (RESULT_VALID),
    .RESULT        (RESULT),
    .READY         (READY)
  );

  initial begin
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // Full precision sum plus bias, rescaled to Q8.8, clipped and sent through the tanh
  function automatic logic [`NTM_DATA_W-1:0] gate_model(input longint acc,
                                                        input logic [`NTM_DATA_W-1:0] bias);
    longint s;
    longint t;
    longint m;
    s = (acc + longint'($signed(bias)) * 256) >>> 8;
    if (s > 32767) s = 32767;
    else if (s < -32768) s = -32768;
    t = (s < 0) ? -s : s;
    if (t < 128) m = t;
    else if (t < 384) m = t / 2 + 64;
    else m = 256;
    if (s < 0) m = -m;
    return m[`NTM_DATA_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [`NTM_DATA_W-1:0] expv,
                                 input logic [`NTM_DATA_W-1:0] got);
    mismatch_errors = mismatch_errors + 1;
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, expv, got);
  endtask

  task automatic close_run();
    $display("Errors: %0d mismatches, %0d protocol", mismatch_errors, protocol_errors);
    if (mismatch_errors + protocol_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic check_idle_outputs();
    if (READY !== 1'b0) report_mismatch("READY", 0, READY);
    if (RESULT_VALID !== 1'b0) report_mismatch("RESULT_VALID", 0, RESULT_VALID);
    if (OPERAND_READY !== 1'b0) report_mismatch("OPERAND_READY", 0, OPERAND_READY);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus building
  ////////////////////////////////////////////////////////////////////

  // Reads one E line and cross-checks its expected value against the model
  task automatic read_element(input integer pairs);
    integer p;
    logic [`NTM_DATA_W-1:0] a;
    logic [`NTM_DATA_W-1:0] b;
    logic [`NTM_DATA_W-1:0] expv;
    longint acc;
    acc = 0;
    code = $fscanf(fd, "%s", tag);
    for (p = 0; p < pairs; p++) begin
      code = $fscanf(fd, "%h %h", a, b);
      op_a.push_back(a);
      op_b.push_back(b);
      acc = acc + longint'($signed(a)) * longint'($signed(b));
    end
    code = $fscanf(fd, "%h %h", a, expv);
    op_a.push_back(a);
    op_b.push_back('0);
    exp_all.push_back(expv);
    if (gate_model(acc, a) !== expv) begin
      protocol_errors = protocol_errors + 1;
      $display("Pattern expects %h but the model gives %h", expv, gate_model(acc, a));
    end
  endtask

  // Operands within +-1.0 and junk in the unused bias field b
  task automatic random_element(input integer pairs);
    integer p;
    logic [`NTM_DATA_W-1:0] a;
    logic [`NTM_DATA_W-1:0] b;
    longint acc;
    acc = 0;
    for (p = 0; p <= pairs; p++) begin
      a = 16'($random(seed) % 257);
      b = 16'($random(seed) % 257);
      op_a.push_back(a);
      op_b.push_back(b);
      if (p < pairs) acc = acc + longint'($signed(a)) * longint'($signed(b));
    end
    exp_all.push_back(gate_model(acc, a));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////

  // Entered and left on a falling edge
  task automatic send_operand(input logic [`NTM_DATA_W-1:0] a,
                              input logic [`NTM_DATA_W-1:0] b, input integer gap);
    OPERAND_VALID = 1'b0;
    repeat (gap) @(negedge CLK);
    OPERAND.a = a;
    OPERAND.b = b;
    OPERAND_VALID = 1'b1;
    while (OPERAND_READY !== 1'b1) @(negedge CLK);
    @(negedge CLK);
    OPERAND_VALID = 1'b0;
  endtask

  task automatic apply_start(input integer sx, input integer sw, input integer sl);
    SIZES.x = sx[`NTM_SIZE_W-1:0];
    SIZES.w = sw[`NTM_SIZE_W-1:0];
    SIZES.l = sl[`NTM_SIZE_W-1:0];
    START = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    // Stream opens one cycle after START
    if (OPERAND_READY !== 1'b1) report_mismatch("OPERAND_READY", 1, OPERAND_READY);
  endtask

  task automatic run_vector(input integer sx, input integer sw, input integer sl,
                            input integer gap_max);
    integer i;
    integer gap;
    exp_q = exp_all;
    exp_index = 0;
    xfers = 0;
    elem_ops = sx + sw + sl + 1;
    limit = limit + 4 * op_a.size() + 20 * sl;
    apply_start(sx, sw, sl);
    for (i = 0; i < op_a.size(); i++) begin
      gap = (gap_max > 0) ? $random(seed) % (gap_max + 1) : 0;
      if (gap < 0) gap = -gap;
      send_operand(op_a[i], op_b[i], gap);
    end
    while (READY !== 1'b1) @(negedge CLK);
    @(negedge CLK);
    if (exp_q.size() != 0) begin
      protocol_errors = protocol_errors + 1;
      $display("Run ended with %0d results missing", exp_q.size());
    end
  endtask

  // Reset hits partway through the first element
  task automatic abort_with_reset(input integer sx, input integer sw, input integer sl,
                                  input integer n);
    integer i;
    limit = limit + 4 * n + 20;
    exp_q.delete();
    xfers = 0;
    elem_ops = sx + sw + sl + 1;
    apply_start(sx, sw, sl);
    for (i = 0; i < n; i++) begin
      send_operand(16'($random(seed) % 257), 16'($random(seed) % 257), 0);
    end
    RST = 1'b1;
    @(negedge CLK);
    check_idle_outputs();
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    check_idle_outputs();
  endtask

  ////////////////////////////////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////////////////////////////////

  // Registered outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (!RST && RESULT_VALID) begin
      if (exp_q.size() == 0) begin
        protocol_errors = protocol_errors + 1;
        $display("Unexpected extra result at %0t, index %0d", $time, RESULT.index);
      end else begin
        popped = exp_q.pop_front();
        if (RESULT.value !== popped) report_mismatch("RESULT.value", popped, RESULT.value);
        if (RESULT.index !== exp_index[`NTM_SIZE_W-1:0]) begin
          report_mismatch("RESULT.index", exp_index[`NTM_DATA_W-1:0], RESULT.index);
        end
        exp_index = exp_index + 1;
      end
    end
    if (!RST && READY && exp_q.size() != 0) begin
      protocol_errors = protocol_errors + 1;
      $display("READY at %0t before the last result", $time);
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    // Stream closed in the TANH cycle after each bias operand
    if (bias_taken && OPERAND_READY !== 1'b0) begin
      report_mismatch("OPERAND_READY", 0, OPERAND_READY);
    end
    bias_taken = 1'b0;
    if (OPERAND_VALID && OPERAND_READY) begin
      xfers = xfers + 1;
      if (xfers % elem_ops == 0) bias_taken = 1'b1;
    end
    if (cycles > limit) begin
      protocol_errors = protocol_errors + 1;
      $display("Timeout: gate still busy after %0d cycles", cycles);
      close_run();
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    RST = 1'b1;
    START = 1'b0;
    SIZES = '0;
    OPERAND_VALID = 1'b0;
    OPERAND = '0;
    seed = 32'hc9953517;
    cycles = 0;
    limit = 100;
    xfers = 0;
    elem_ops = 1;
    bias_taken = 1'b0;
    exp_index = 0;
    mismatch_errors = 0;
    protocol_errors = 0;
    done = 0;
    repeat (4) @(negedge CLK);
    check_idle_outputs();
    RST = 1'b0;
    @(negedge CLK);
    fd = $fopen("tb/ntm_gate_patterns.txt", "r");
    if (fd == 0) begin
      protocol_errors = protocol_errors + 1;
      $display("Cannot open tb/ntm_gate_patterns.txt");
      done = 1;
    end
    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        done = 1;
      end else if (tag == "#") begin
        code = $fgets(line, fd);
      end else if (tag == "S") begin
        code = $fscanf(fd, "%d %d %d %d", x, w, l, arg);
        op_a.delete();
        op_b.delete();
        exp_all.delete();
        for (e = 0; e < l; e++) read_element(x + w + l);
        run_vector(x, w, l, arg);
      end else if (tag == "R") begin
        code = $fscanf(fd, "%d %d %d %d", x, w, l, arg);
        for (r = 0; r < arg; r++) begin
          op_a.delete();
          op_b.delete();
          exp_all.delete();
          for (e = 0; e < l; e++) random_element(x + w + l);
          // Same operands with and without host gaps
          run_vector(x, w, l, 0);
          run_vector(x, w, l, 3);
        end
      end else if (tag == "X") begin
        code = $fscanf(fd, "%d %d %d %d", x, w, l, arg);
        abort_with_reset(x, w, l, arg);
      end else begin
        protocol_errors = protocol_errors + 1;
        $display("Unknown line tag in the pattern file");
        done = 1;
      end
    end
    if (fd != 0) $fclose(fd);
    close_run();
  end

endmodule

// File: sim.f
+incdir+design
design/ntm_pkg.sv
design/ntm_gate_controller.sv
design/ntm_element_counter.sv
design/ntm_mac_unit.sv
design/ntm_tanh_unit.sv
design/ntm_activation_gate_vector.sv
tb/ntm_gate_assertions.sv
tb/ntm_gate_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the NTM activation gate testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module ntm_gate_tb -Mdir obj_dir -o ntm_gate_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/ntm_gate_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  exit 1
fi
exit 0

// File: tb/ntm_gate_patterns.txt
# S x w l gap : directed run, then l lines E with x+w+l pairs a b, bias, expected (hex Q8.8)
# R x w l count : random runs, each streamed gap-free and with gaps; X x w l n : reset after n
S 1 1 1 0
E 0080 0040 0100 0020 0040 0040 0010 0060
S 3 2 4 0
E 0100 0010 0100 0010 0100 0010 0100 0008 0100 0008 0100 0004 0100 0004 0100 0004 0100 0004 0000 0050
E 0100 FFF0 0100 FFF0 0100 FFF0 0100 FFF8 0100 FFF8 0100 FFFC 0100 FFFC 0100 FFFC 0100 FFFC FFE0 FF90
E 0100 0040 0100 0040 0100 0040 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0100 0000 0040 00C0
E 0200 0020 0200 0020 0200 0020 0200 0010 0200 0010 0200 FFF0 0200 FFF0 0200 FFF0 0200 FFF0 0000 0080
S 2 1 3 0
E 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 0100
E 8000 7FFF 8000 7FFF 8000 7FFF 8000 7FFF 8000 7FFF 8000 7FFF 8000 FF00
E 0100 FF80 0100 FFAC 0100 0000 0100 0000 0100 0000 0100 0000 FFA8 FF2A
R 2 3 2 2
S 1 1 1 2
E 0080 0040 0100 0020 0040 0040 0010 0060
X 3 2 2 5
S 1 1 1 0
E 0080 0040 0100 0020 0040 0040 0010 0060
R 8 8 8 1
R 1 1 1 3
